//--- logic/ifm_buffer_macros.svh
`ifndef IFM_BUFFER_MACROS_SVH
`define IFM_BUFFER_MACROS_SVH

// Word and map geometry.
`define IFM_DATA_WIDTH 32
`define IFM_SIZE 5
`define IFM_MAP_WORDS (`IFM_SIZE * `IFM_SIZE)
`define IFM_ADDR_WIDTH 5

// Map count and grouping.
`define IFM_NUM_MAPS 16
`define IFM_LANES 3

// Last group holds one real map.
`define IFM_NUM_GROUPS 6
`define IFM_GROUP_WIDTH 3

`endif

//--- logic/ifm_buffer_pkg.sv
package ifm_buffer_pkg;

	`include "ifm_buffer_macros.svh"

	// One feature map word.
	typedef logic [`IFM_DATA_WIDTH-1:0] data_t;

	// Word address inside one 5x5 map.
	typedef logic [`IFM_ADDR_WIDTH-1:0] addr_t;

	// Index of a three-lane group.
	typedef logic [`IFM_GROUP_WIDTH-1:0] group_t;

	// Three lanes side by side, lane 0 in the low word.
	typedef data_t [`IFM_LANES-1:0] lane_data_t;

	// One output side of every group.
	typedef lane_data_t [`IFM_NUM_GROUPS-1:0] group_data_t;

endpackage

//--- logic/ifm_bank_ctrl.sv
`timescale 1ns/10ps

`include "ifm_buffer_macros.svh"

module ifm_bank_ctrl
	import ifm_buffer_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   swap,
	output group_t write_group,
	output group_t read_group
);

	// Next group index, wrapping after the last group.
	function automatic group_t next_group(input group_t cur);
		group_t nxt;
		if (cur == group_t'(`IFM_NUM_GROUPS - 1))
			nxt = '0;
		else
			nxt = cur + group_t'(1);
		return nxt;
	endfunction

	// Read group trails the write group by one.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			write_group <= '0;
			read_group  <= group_t'(`IFM_NUM_GROUPS - 1);
		end
		else if (swap)
		begin
			write_group <= next_group(write_group);
			read_group  <= next_group(read_group);
		end
	end

endmodule

//--- logic/ifm_port_router.sv
`timescale 1ns/10ps

`include "ifm_buffer_macros.svh"

module ifm_port_router
	import ifm_buffer_pkg::*;
(
	input  group_t                      write_group,
	input  group_t                      read_group,
	input  logic                        wr_en,
	input  addr_t                       wr_addr,
	input  logic                        prev_rd_en,
	input  addr_t                       prev_rd_addr,
	input  logic                        next_rd_a_en,
	input  addr_t                       next_rd_a_addr,
	input  logic                        next_rd_b_en,
	input  addr_t                       next_rd_b_addr,
	output logic [`IFM_NUM_GROUPS-1:0]  port_a_we,
	output logic [`IFM_NUM_GROUPS-1:0]  port_a_re,
	output logic [`IFM_NUM_GROUPS-1:0]  port_b_re,
	output addr_t [`IFM_NUM_GROUPS-1:0] port_a_addr,
	output addr_t [`IFM_NUM_GROUPS-1:0] port_b_addr
);

	// One-hot group hits.
	logic [`IFM_NUM_GROUPS-1:0] wr_hit;
	logic [`IFM_NUM_GROUPS-1:0] rd_hit;

	for (genvar g = 0; g < `IFM_NUM_GROUPS; g++)
	begin : g_group
		assign wr_hit[g] = (write_group == group_t'(g));
		assign rd_hit[g] = (read_group == group_t'(g));

		// Port A writes for the previous layer, reads for next layer A.
		assign port_a_we[g] = wr_hit[g] & wr_en;
		assign port_a_re[g] = rd_hit[g] & next_rd_a_en;

		// Port B is read-only, shared by read-back and next layer B.
		assign port_b_re[g] = (wr_hit[g] & prev_rd_en) | (rd_hit[g] & next_rd_b_en);

		always_comb
		begin
			if (wr_hit[g])
			begin
				port_a_addr[g] = wr_addr;
				port_b_addr[g] = prev_rd_addr;
			end
			else if (rd_hit[g])
			begin
				port_a_addr[g] = next_rd_a_addr;
				port_b_addr[g] = next_rd_b_addr;
			end
			else
			begin
				// Idle groups see a quiet bus.
				port_a_addr[g] = '0;
				port_b_addr[g] = '0;
			end
		end
	end

endmodule

//--- logic/ifm_map_ram.sv
`timescale 1ns/10ps

module ifm_map_ram #(
	parameter int DATA_WIDTH = 32,
	parameter int WORDS      = 25
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     a_we,
	input  logic                     a_re,
	input  logic [$clog2(WORDS)-1:0] a_addr,
	input  logic [DATA_WIDTH-1:0]    a_wdata,
	input  logic                     b_re,
	input  logic [$clog2(WORDS)-1:0] b_addr,
	output logic [DATA_WIDTH-1:0]    a_rdata,
	output logic [DATA_WIDTH-1:0]    b_rdata
);

	logic [DATA_WIDTH-1:0] mem [WORDS];

	always_ff @(posedge clk)
	begin
		if (a_we)
			mem[a_addr] <= a_wdata;
	end

	// Output registers hold until the next read; old word on a collision.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			a_rdata <= '0;
			b_rdata <= '0;
		end
		else
		begin
			if (a_re)
				a_rdata <= mem[a_addr];
			if (b_re)
				b_rdata <= mem[b_addr];
		end
	end

endmodule

//--- logic/ifm_bank_array.sv
`timescale 1ns/10ps

`include "ifm_buffer_macros.svh"

module ifm_bank_array
	import ifm_buffer_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic [`IFM_NUM_GROUPS-1:0]  port_a_we,
	input  logic [`IFM_NUM_GROUPS-1:0]  port_a_re,
	input  logic [`IFM_NUM_GROUPS-1:0]  port_b_re,
	input  addr_t [`IFM_NUM_GROUPS-1:0] port_a_addr,
	input  addr_t [`IFM_NUM_GROUPS-1:0] port_b_addr,
	input  lane_data_t                  wr_data,
	output group_data_t                 group_a_data,
	output group_data_t                 group_b_data
);

	// Map m lives in group m/3, lane m%3.
	for (genvar g = 0; g < `IFM_NUM_GROUPS; g++)
	begin : g_group
		for (genvar l = 0; l < `IFM_LANES; l++)
		begin : g_lane
			if (g * `IFM_LANES + l < `IFM_NUM_MAPS)
			begin : g_map
				ifm_map_ram #(
					.DATA_WIDTH (`IFM_DATA_WIDTH),
					.WORDS      (`IFM_MAP_WORDS)
				) u_ram (
					.clk     (clk),
					.rst     (rst),
					.a_we    (port_a_we[g]),
					.a_re    (port_a_re[g]),
					.a_addr  (port_a_addr[g]),
					.a_wdata (wr_data[l]),
					.b_re    (port_b_re[g]),
					.b_addr  (port_b_addr[g]),
					.a_rdata (group_a_data[g][l]),
					.b_rdata (group_b_data[g][l])
				);
			end
			else
			begin : g_empty
				// No map behind this lane.
				assign group_a_data[g][l] = '0;
				assign group_b_data[g][l] = '0;
			end
		end
	end

endmodule

//--- logic/ifm_lane_mux.sv
`timescale 1ns/10ps

module ifm_lane_mux
	import ifm_buffer_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  group_t      write_group,
	input  group_t      read_group,
	input  group_data_t group_a_data,
	input  group_data_t group_b_data,
	output lane_data_t  prev_rd_data,
	output lane_data_t  next_rd_a_data,
	output lane_data_t  next_rd_b_data
);

	// Groups seen at the edge that loaded the RAM outputs.
	group_t write_group_q;
	group_t read_group_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			write_group_q <= '0;
			read_group_q  <= '0;
		end
		else
		begin
			write_group_q <= write_group;
			read_group_q  <= read_group;
		end
	end

	// Previous layer reads back its own group on port B.
	assign prev_rd_data = group_b_data[write_group_q];

	// Next layer sees the group before it on both ports.
	assign next_rd_a_data = group_a_data[read_group_q];
	assign next_rd_b_data = group_b_data[read_group_q];

endmodule

//--- logic/ifm_buffer_top.sv
`timescale 1ns/10ps

`include "ifm_buffer_macros.svh"

module ifm_buffer_top
	import ifm_buffer_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       swap,
	input  logic       wr_en,
	input  addr_t      wr_addr,
	input  lane_data_t wr_data,
	input  logic       prev_rd_en,
	input  addr_t      prev_rd_addr,
	input  logic       next_rd_a_en,
	input  addr_t      next_rd_a_addr,
	input  logic       next_rd_b_en,
	input  addr_t      next_rd_b_addr,
	output lane_data_t prev_rd_data,
	output lane_data_t next_rd_a_data,
	output lane_data_t next_rd_b_data,
	output group_t     write_group,
	output group_t     read_group
);

	logic [`IFM_NUM_GROUPS-1:0]  port_a_we;
	logic [`IFM_NUM_GROUPS-1:0]  port_a_re;
	logic [`IFM_NUM_GROUPS-1:0]  port_b_re;
	addr_t [`IFM_NUM_GROUPS-1:0] port_a_addr;
	addr_t [`IFM_NUM_GROUPS-1:0] port_b_addr;
	group_data_t                 group_a_data;
	group_data_t                 group_b_data;

	ifm_bank_ctrl u_bank_ctrl (
		.clk         (clk),
		.rst         (rst),
		.swap        (swap),
		.write_group (write_group),
		.read_group  (read_group)
	);

	ifm_port_router u_port_router (
		.write_group    (write_group),
		.read_group     (read_group),
		.wr_en          (wr_en),
		.wr_addr        (wr_addr),
		.prev_rd_en     (prev_rd_en),
		.prev_rd_addr   (prev_rd_addr),
		.next_rd_a_en   (next_rd_a_en),
		.next_rd_a_addr (next_rd_a_addr),
		.next_rd_b_en   (next_rd_b_en),
		.next_rd_b_addr (next_rd_b_addr),
		.port_a_we      (port_a_we),
		.port_a_re      (port_a_re),
		.port_b_re      (port_b_re),
		.port_a_addr    (port_a_addr),
		.port_b_addr    (port_b_addr)
	);

	// Sixteen maps, group 5 has lane 0 only.
	ifm_bank_array u_bank_array (
		.clk          (clk),
		.rst          (rst),
		.port_a_we    (port_a_we),
		.port_a_re    (port_a_re),
		.port_b_re    (port_b_re),
		.port_a_addr  (port_a_addr),
		.port_b_addr  (port_b_addr),
		.wr_data      (wr_data),
		.group_a_data (group_a_data),
		.group_b_data (group_b_data)
	);

	ifm_lane_mux u_lane_mux (
		.clk            (clk),
		.rst            (rst),
		.write_group    (write_group),
		.read_group     (read_group),
		.group_a_data   (group_a_data),
		.group_b_data   (group_b_data),
		.prev_rd_data   (prev_rd_data),
		.next_rd_a_data (next_rd_a_data),
		.next_rd_b_data (next_rd_b_data)
	);

endmodule

//--- verification/ifm_buffer_checks.sv
`timescale 1ns/10ps

module ifm_buffer_checks
	import ifm_buffer_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       prev_rd_en,
	input  logic       next_rd_a_en,
	input  logic       next_rd_b_en,
	input  lane_data_t prev_rd_data,
	input  lane_data_t next_rd_a_data,
	input  lane_data_t next_rd_b_data,
	input  group_t     write_group,
	input  group_t     read_group,
	input  lane_data_t prev_exp,
	input  lane_data_t next_a_exp,
	input  lane_data_t next_b_exp,
	input  group_t     exp_write_group,
	input  group_t     exp_read_group,
	output int         err_count
);

	// Expected words trail their read enables by one cycle.
	logic       prev_chk_q;
	logic       next_a_chk_q;
	logic       next_b_chk_q;
	lane_data_t prev_exp_q;
	lane_data_t next_a_exp_q;
	lane_data_t next_b_exp_q;

	initial
		err_count = 0;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			prev_chk_q   <= 1'b0;
			next_a_chk_q <= 1'b0;
			next_b_chk_q <= 1'b0;
		end
		else
		begin
			prev_chk_q   <= prev_rd_en;
			next_a_chk_q <= next_rd_a_en;
			next_b_chk_q <= next_rd_b_en;
		end
		prev_exp_q   <= prev_exp;
		next_a_exp_q <= next_a_exp;
		next_b_exp_q <= next_b_exp;
	end

	// First edge out of reset.
	reset_outputs: assert property (@(posedge clk) $fell(rst) |->
		(prev_rd_data == '0 && next_rd_a_data == '0 && next_rd_b_data == '0))
	else
	begin
		err_count++;
		$display("Error: reset outputs expected 0, prev_rd_data=%h next_rd_a_data=%h",
			$sampled(prev_rd_data), $sampled(next_rd_a_data));
		$display("Error: reset outputs expected 0, next_rd_b_data=%h", $sampled(next_rd_b_data));
	end

	prev_data: assert property (@(posedge clk) disable iff (rst)
		prev_chk_q |-> prev_rd_data == prev_exp_q)
	else
	begin
		err_count++;
		$display("Error: prev_rd_data expected %h got %h at %0t",
			$sampled(prev_exp_q), $sampled(prev_rd_data), $time);
	end

	next_a_data: assert property (@(posedge clk) disable iff (rst)
		next_a_chk_q |-> next_rd_a_data == next_a_exp_q)
	else
	begin
		err_count++;
		$display("Error: next_rd_a_data expected %h got %h at %0t",
			$sampled(next_a_exp_q), $sampled(next_rd_a_data), $time);
	end

	next_b_data: assert property (@(posedge clk) disable iff (rst)
		next_b_chk_q |-> next_rd_b_data == next_b_exp_q)
	else
	begin
		err_count++;
		$display("Error: next_rd_b_data expected %h got %h at %0t",
			$sampled(next_b_exp_q), $sampled(next_rd_b_data), $time);
	end

	groups: assert property (@(posedge clk) disable iff (rst)
		write_group == exp_write_group && read_group == exp_read_group)
	else
	begin
		err_count++;
		$display("Error: write_group expected %h got %h, read_group expected %h got %h",
			$sampled(exp_write_group), $sampled(write_group),
			$sampled(exp_read_group), $sampled(read_group));
	end

endmodule

//--- verification/ifm_buffer_tb.sv
`timescale 1ns/10ps

`include "ifm_buffer_macros.svh"

module ifm_buffer_tb
	import ifm_buffer_pkg::*;
();

	localparam int CLK_PERIOD   = 100;
	localparam int DRIVE_DELAY  = 10;
	localparam int RESET_CYCLES = 10;
	localparam int SEED         = 46522;

	// Cycles per test, one idle cycle each for the report.
	localparam int T1_CYCLES = 4;
	localparam int T2_CYCLES = `IFM_NUM_GROUPS * 2 * `IFM_MAP_WORDS;
	localparam int T3_CYCLES = 2 * `IFM_MAP_WORDS;
	localparam int T4_CYCLES = 3 * `IFM_NUM_GROUPS;
	localparam int T5_CYCLES = 2 * `IFM_NUM_GROUPS * (`IFM_MAP_WORDS + 1);
	localparam int TOTAL_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
		+ T4_CYCLES + T5_CYCLES + 5;
	localparam int WATCHDOG_CYCLES = TOTAL_CYCLES * 3 / 2;

	logic       clk;
	logic       rst;
	logic       swap;
	logic       wr_en;
	addr_t      wr_addr;
	lane_data_t wr_data;
	logic       prev_rd_en;
	addr_t      prev_rd_addr;
	logic       next_rd_a_en;
	addr_t      next_rd_a_addr;
	logic       next_rd_b_en;
	addr_t      next_rd_b_addr;
	lane_data_t prev_rd_data;
	lane_data_t next_rd_a_data;
	lane_data_t next_rd_b_data;
	group_t     write_group;
	group_t     read_group;

	// Reference model.
	data_t      model_mem [`IFM_NUM_MAPS][`IFM_MAP_WORDS];
	group_t     model_wg;
	group_t     model_rg;
	lane_data_t prev_exp;
	lane_data_t next_a_exp;
	lane_data_t next_b_exp;

	int err_count;
	int errs_at_start;
	int tests_run;
	int tests_failed;

	ifm_buffer_top DUT (
		.clk            (clk),
		.rst            (rst),
		.swap           (swap),
		.wr_en          (wr_en),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.prev_rd_en     (prev_rd_en),
		.prev_rd_addr   (prev_rd_addr),
		.next_rd_a_en   (next_rd_a_en),
		.next_rd_a_addr (next_rd_a_addr),
		.next_rd_b_en   (next_rd_b_en),
		.next_rd_b_addr (next_rd_b_addr),
		.prev_rd_data   (prev_rd_data),
		.next_rd_a_data (next_rd_a_data),
		.next_rd_b_data (next_rd_b_data),
		.write_group    (write_group),
		.read_group     (read_group)
	);

	ifm_buffer_checks u_checks (
		.clk             (clk),
		.rst             (rst),
		.prev_rd_en      (prev_rd_en),
		.next_rd_a_en    (next_rd_a_en),
		.next_rd_b_en    (next_rd_b_en),
		.prev_rd_data    (prev_rd_data),
		.next_rd_a_data  (next_rd_a_data),
		.next_rd_b_data  (next_rd_b_data),
		.write_group     (write_group),
		.read_group      (read_group),
		.prev_exp        (prev_exp),
		.next_a_exp      (next_a_exp),
		.next_b_exp      (next_b_exp),
		.exp_write_group (model_wg),
		.exp_read_group  (model_rg),
		.err_count       (err_count)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Swap advances the write group, wrapping after group 5.
	always @(posedge clk)
	begin
		if (rst)
			model_wg <= '0;
		else if (swap)
			model_wg <= (model_wg == group_t'(`IFM_NUM_GROUPS - 1)) ? '0 : model_wg + 1'b1;
	end

	assign model_rg = (model_wg == '0) ? group_t'(`IFM_NUM_GROUPS - 1) : model_wg - 1'b1;

	// Lanes with no map read as zero.
	function automatic lane_data_t expect_lanes(input group_t g, input addr_t a);
		lane_data_t d;
		int m;
		for (int l = 0; l < `IFM_LANES; l++)
		begin
			m = int'(g) * `IFM_LANES + l;
			if (m < `IFM_NUM_MAPS)
				d[l] = model_mem[m][a];
			else
				d[l] = '0;
		end
		return d;
	endfunction

	task automatic set_write(input addr_t a);
		int m;
		wr_en   = 1'b1;
		wr_addr = a;
		for (int l = 0; l < `IFM_LANES; l++)
		begin
			wr_data[l] = $urandom();
			m = int'(model_wg) * `IFM_LANES + l;
			if (m < `IFM_NUM_MAPS)
				model_mem[m][a] = wr_data[l];
		end
	endtask

	task automatic set_prev_read(input addr_t a);
		prev_rd_en   = 1'b1;
		prev_rd_addr = a;
		prev_exp     = expect_lanes(model_wg, a);
	endtask

	task automatic set_next_reads(input addr_t a, input addr_t b);
		next_rd_a_en   = 1'b1;
		next_rd_a_addr = a;
		next_a_exp     = expect_lanes(model_rg, a);
		next_rd_b_en   = 1'b1;
		next_rd_b_addr = b;
		next_b_exp     = expect_lanes(model_rg, b);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
		swap         = 1'b0;
		wr_en        = 1'b0;
		prev_rd_en   = 1'b0;
		next_rd_a_en = 1'b0;
		next_rd_b_en = 1'b0;
	endtask

	task automatic end_test(input string name);
		// Last read is checked at the following edge.
		next_cycle();
		tests_run++;
		if (err_count == errs_at_start)
			$display("Test %0d %s: pass", tests_run, name);
		else
		begin
			tests_failed++;
			$display("Test %0d %s: fail, %0d errors", tests_run, name, err_count - errs_at_start);
		end
		errs_at_start = err_count;
	endtask

	initial
	begin
		void'($urandom(SEED));
		rst            = 1'b1;
		swap           = 1'b0;
		wr_en          = 1'b0;
		wr_addr        = '0;
		wr_data        = '0;
		prev_rd_en     = 1'b0;
		prev_rd_addr   = '0;
		next_rd_a_en   = 1'b0;
		next_rd_a_addr = '0;
		next_rd_b_en   = 1'b0;
		next_rd_b_addr = '0;
		prev_exp       = '0;
		next_a_exp     = '0;
		next_b_exp     = '0;
		errs_at_start  = 0;
		tests_run      = 0;
		tests_failed   = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;

		repeat (T1_CYCLES) next_cycle();
		end_test("reset state");

		// Fill each group, read it back, swap on the last read.
		for (int g = 0; g < `IFM_NUM_GROUPS; g++)
		begin
			for (int a = 0; a < `IFM_MAP_WORDS; a++)
			begin
				set_write(addr_t'(a));
				next_cycle();
			end
			for (int a = 0; a < `IFM_MAP_WORDS; a++)
			begin
				set_prev_read(addr_t'(a));
				if (a == `IFM_MAP_WORDS - 1)
					swap = 1'b1;
				next_cycle();
			end
		end
		end_test("write and read back");

		for (int r = 0; r < 2; r++)
		begin
			for (int a = 0; a < `IFM_MAP_WORDS; a++)
			begin
				set_next_reads(addr_t'(a), addr_t'((a + 7) % `IFM_MAP_WORDS));
				if (a == `IFM_MAP_WORDS - 1)
					swap = 1'b1;
				next_cycle();
			end
		end
		end_test("next-layer reads");

		while (model_wg != '0)
		begin
			swap = 1'b1;
			next_cycle();
		end
		repeat (`IFM_NUM_GROUPS)
		begin
			swap = 1'b1;
			next_cycle();
			next_cycle();
		end
		end_test("group wrap");

		// Overwrite every map while reading the same address and the read group.
		for (int g = 0; g < `IFM_NUM_GROUPS; g++)
		begin
			for (int a = 0; a < `IFM_MAP_WORDS; a++)
			begin
				set_next_reads(addr_t'(a), addr_t'((a + 12) % `IFM_MAP_WORDS));
				set_prev_read(addr_t'(a));
				set_write(addr_t'(a));
				next_cycle();
			end
			swap = 1'b1;
			next_cycle();
		end
		for (int g = 0; g < `IFM_NUM_GROUPS; g++)
		begin
			for (int a = 0; a < `IFM_MAP_WORDS; a++)
			begin
				set_prev_read(addr_t'(a));
				set_next_reads(addr_t'(a), addr_t'(`IFM_MAP_WORDS - 1 - a));
				next_cycle();
			end
			swap = 1'b1;
			next_cycle();
		end
		end_test("isolation and read-first");

		$display("Tests: %0d run, %0d failed, %0d assertion errors",
			tests_run, tests_failed, err_count);
		if (tests_failed == 0 && err_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+logic
logic/ifm_buffer_pkg.sv
logic/ifm_bank_ctrl.sv
logic/ifm_port_router.sv
logic/ifm_map_ram.sv
logic/ifm_bank_array.sv
logic/ifm_lane_mux.sv
logic/ifm_buffer_top.sv
verification/ifm_buffer_checks.sv
verification/ifm_buffer_tb.sv
